// File: beat_tracker/beat_tracker.sv
`timescale 1ns/1ps

module beat_tracker (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          i_start,
  input  logic [vec_pkg::CW-1:0]        i_nb1,
  output logic                          o_ram_re,
  output logic [vec_pkg::RAM_RD_AW-1:0] o_ram_raddr,
  input  vec_pkg::bundle_t              i_ram_data,
  input  logic                          i_o_valid,
  input  logic                          i_o_ready,
  output vec_pkg::loop_state_t          o_loop,
  output logic                          o_done,
  output logic                          o_armed
);

  typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_LOAD, ST_RUN} state_t;

  state_t           state;
  vec_pkg::bundle_t bnd;
  logic             beat, clr;
  logic             wrap_wlast, wrap_coe, wrap_w_kw2, wrap_l, wrap_n, wrap_t, wrap_p, wrap_b;
  logic [vec_pkg::CW-1:0] max_wlast, max_w_kw2;

  assign o_armed     = (state == ST_RUN);
  assign o_ram_re    = (state == ST_FETCH);
  assign o_ram_raddr = o_loop.i_b[vec_pkg::RAM_RD_AW-1:0];
  assign beat        = o_armed && i_o_valid && i_o_ready;
  assign clr         = i_start || (state == ST_LOAD);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state  <= ST_IDLE;
      o_done <= 1'b0;
    end else if (i_start) begin
      state  <= ST_FETCH;
      o_done <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: state <= ST_LOAD;
        ST_LOAD:  state <= ST_RUN;
        ST_RUN: begin
          if (wrap_p) begin
            state  <= wrap_b ? ST_IDLE : ST_FETCH;
            o_done <= wrap_b; // Last beat of bundle nb1
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_LOAD)
      bnd <= i_ram_data;
  end

  // Last w step carries the extra kw/2 beats
  assign max_w_kw2 = bnd.w_kw2 - 1'b1;
  assign max_wlast = (o_loop.i_w_kw2 == max_w_kw2) ? (bnd.kw >> 1) : '0;

  loop_counter c_wlast (
    .clk(clk), .rstn(rstn), .i_clear(clr), .i_en(beat), .i_max(max_wlast),
    .o_count(o_loop.i_wlast), .o_next(), .o_wrap(wrap_wlast)
  );
  loop_counter c_coe (
    .clk(clk), .rstn(rstn), .i_clear(clr), .i_en(wrap_wlast), .i_max(bnd.coe - 1'b1),
    .o_count(o_loop.i_coe), .o_next(), .o_wrap(wrap_coe)
  );
  loop_counter c_w_kw2 (
    .clk(clk), .rstn(rstn), .i_clear(clr), .i_en(wrap_coe), .i_max(max_w_kw2),
    .o_count(o_loop.i_w_kw2), .o_next(), .o_wrap(wrap_w_kw2)
  );
  loop_counter c_l (
    .clk(clk), .rstn(rstn), .i_clear(clr), .i_en(wrap_w_kw2), .i_max(bnd.l - 1'b1),
    .o_count(o_loop.i_l), .o_next(), .o_wrap(wrap_l)
  );
  loop_counter c_n (
    .clk(clk), .rstn(rstn), .i_clear(clr), .i_en(wrap_l), .i_max(bnd.n - 1'b1),
    .o_count(o_loop.i_n), .o_next(), .o_wrap(wrap_n)
  );
  loop_counter c_t (
    .clk(clk), .rstn(rstn), .i_clear(clr), .i_en(wrap_n), .i_max(bnd.t - 1'b1),
    .o_count(o_loop.i_t), .o_next(), .o_wrap(wrap_t)
  );
  loop_counter c_p (
    .clk(clk), .rstn(rstn), .i_clear(clr), .i_en(wrap_t), .i_max(bnd.p - 1'b1),
    .o_count(o_loop.i_p), .o_next(), .o_wrap(wrap_p)
  );
  // Bundle index only restarts on a new start
  loop_counter c_b (
    .clk(clk), .rstn(rstn), .i_clear(i_start), .i_en(wrap_p), .i_max(i_nb1),
    .o_count(o_loop.i_b), .o_next(), .o_wrap(wrap_b)
  );

endmodule

// File: beat_tracker/loop_counter.sv
`timescale 1ns/1ps

module loop_counter (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   i_clear,
  input  logic                   i_en,
  input  logic [vec_pkg::CW-1:0] i_max,
  output logic [vec_pkg::CW-1:0] o_count,
  output logic [vec_pkg::CW-1:0] o_next,
  output logic                   o_wrap
);

  assign o_wrap = i_en && (o_count == i_max);

  always_comb begin
    if (i_clear)
      o_next = '0;
    else if (o_wrap)
      o_next = '0;
    else if (i_en)
      o_next = o_count + 1'b1;
    else
      o_next = o_count;
  end

  always_ff @(posedge clk) begin
    if (!rstn)
      o_count <= '0;
    else
      o_count <= o_next;
  end

endmodule

// File: bench/tb_vector_cfg.sv
`timescale 1ns/1ps

module tb_vector_cfg;

  localparam int SEED        = 32'h4403_8c48;
  localparam int HS_TIMEOUT  = 64;
  localparam int RUN_TIMEOUT = 100000;

  logic                       clk = 1'b0;
  logic                       rstn = 1'b0;
  logic [vec_pkg::ADDR_W-1:0] i_awaddr = '0, i_araddr = '0;
  logic [vec_pkg::DATA_W-1:0] i_wdata = '0, o_rdata;
  logic                       i_awvalid = 1'b0, i_wvalid = 1'b0, i_bready = 1'b0;
  logic                       i_arvalid = 1'b0, i_rready = 1'b0;
  logic                       i_o_valid = 1'b0, i_o_ready = 1'b0;
  logic                       o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
  logic                       o_done, o_armed;

  vec_pkg::bundle_t tbl [vec_pkg::MAX_BUNDLES];
  int               nb1, total_beats;
  int               errors = 0;
  int               cnt [8];  // Model counts, wlast innermost to b outermost
  logic [31:0]      rd;

  vector_cfg_top dut_i (.*);

  always #2 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic axil_write(input int word, input logic [31:0] data);
    int t;
    int stall;
    i_awaddr  = vec_pkg::ADDR_W'(word * 4);
    i_wdata   = data;
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    t = 0;
    while (!o_awready) begin
      @(negedge clk);
      t++;
      if (t > HS_TIMEOUT) fail_timeout("awready");
    end
    check_eq("o_wready", o_wready, 1);
    @(negedge clk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    check_eq("o_awready", o_awready, 0); // One-cycle accept pulse
    stall = $urandom_range(0, 4);
    for (int k = 0; k < stall; k++) begin
      check_eq("o_bvalid", o_bvalid, 1); // Held through bready stall
      @(negedge clk);
    end
    i_bready = 1'b1;
    t = 0;
    while (!o_bvalid) begin
      @(negedge clk);
      t++;
      if (t > HS_TIMEOUT) fail_timeout("bvalid");
    end
    @(negedge clk);
    i_bready = 1'b0;
    check_eq("o_bvalid", o_bvalid, 0); // Exactly one response
  endtask

  task automatic axil_read(input int word, output logic [31:0] data);
    int t;
    int stall;
    i_araddr  = vec_pkg::ADDR_W'(word * 4);
    i_arvalid = 1'b1;
    t = 0;
    while (!o_arready) begin
      @(negedge clk);
      t++;
      if (t > HS_TIMEOUT) fail_timeout("arready");
    end
    @(negedge clk);
    i_arvalid = 1'b0;
    check_eq("o_arready", o_arready, 0);
    stall = $urandom_range(0, 4);
    for (int k = 0; k < stall; k++) begin
      check_eq("o_rvalid", o_rvalid, 1);
      @(negedge clk);
    end
    i_rready = 1'b1;
    t = 0;
    while (!o_rvalid) begin
      @(negedge clk);
      t++;
      if (t > HS_TIMEOUT) fail_timeout("rvalid");
    end
    data = o_rdata;
    @(negedge clk);
    i_rready = 1'b0;
    check_eq("o_rvalid", o_rvalid, 0);
  endtask

  // Beats per bundle from the loop bounds
  function automatic int bundle_beats(input vec_pkg::bundle_t bd);
    int s;
    s = 0;
    for (int w = 0; w < int'(bd.w_kw2); w++)
      s += (w == int'(bd.w_kw2) - 1) ? int'(bd.kw) / 2 + 1 : 1;
    return int'(bd.p) * int'(bd.t) * int'(bd.n) * int'(bd.l) * int'(bd.coe) * s;
  endfunction

  task automatic model_step();
    vec_pkg::bundle_t bd;
    int               lim [8];
    bit               carry;
    bd = tbl[cnt[7]];
    lim[0] = (cnt[2] == int'(bd.w_kw2) - 1) ? int'(bd.kw) / 2 : 0;
    lim[1] = int'(bd.coe) - 1;
    lim[2] = int'(bd.w_kw2) - 1;
    lim[3] = int'(bd.l) - 1;
    lim[4] = int'(bd.n) - 1;
    lim[5] = int'(bd.t) - 1;
    lim[6] = int'(bd.p) - 1;
    lim[7] = nb1;
    carry = 1'b1;
    for (int k = 0; k < 8; k++) begin
      if (carry) begin
        if (cnt[k] == lim[k]) begin
          cnt[k] = 0;
        end else begin
          cnt[k]++;
          carry = 1'b0;
        end
      end
    end
  endtask

  task automatic check_loop();
    logic [31:0] exp [4];
    logic [31:0] got;
    exp[0] = {cnt[6][15:0], cnt[7][15:0]};  // i_p, i_b
    exp[1] = {cnt[4][15:0], cnt[5][15:0]};
    exp[2] = {cnt[2][15:0], cnt[3][15:0]};
    exp[3] = {cnt[0][15:0], cnt[1][15:0]};
    for (int k = 0; k < 4; k++) begin
      axil_read(vec_pkg::REG_LOOP + k, got);
      check_eq($sformatf("o_rdata (loop word %0d)", vec_pkg::REG_LOOP + k), got, exp[k]);
    end
  endtask

  task automatic load_table();
    logic [127:0] flat;
    nb1 = $urandom_range(2, 4);
    total_beats = 0;
    for (int b = 0; b <= nb1; b++) begin
      tbl[b].kw    = 16'($urandom_range(0, 5));
      tbl[b].coe   = 16'($urandom_range(1, 3));
      tbl[b].w_kw2 = 16'($urandom_range(1, 3));
      tbl[b].l     = 16'($urandom_range(1, 2));
      tbl[b].n     = 16'($urandom_range(1, 2));
      tbl[b].t     = 16'($urandom_range(1, 2));
      tbl[b].p     = 16'($urandom_range(1, 2));
      tbl[b].spare = 16'($urandom);
      total_beats += bundle_beats(tbl[b]);
      flat = tbl[b];
      for (int s = 0; s < 4; s++)
        axil_write(vec_pkg::N_REG + b * 4 + s, flat[32*s +: 32]);
    end
    axil_write(vec_pkg::REG_NB1, nb1);
  endtask

  task automatic start_run();
    int t;
    foreach (cnt[k]) cnt[k] = 0;
    axil_write(vec_pkg::REG_START, $urandom);
    t = 0;
    while (!o_armed) begin
      @(negedge clk);
      t++;
      if (t > HS_TIMEOUT) fail_timeout("armed after start");
    end
  endtask

  task automatic run_beats();
    int beats;
    int cycles;
    beats = 0;
    cycles = 0;
    while (beats < total_beats) begin
      @(negedge clk);
      check_eq("o_done", o_done, 0);
      cycles++;
      if (cycles > RUN_TIMEOUT) fail_timeout("last beat");
      if ($urandom_range(0, 31) == 0) begin
        i_o_valid = 1'b0; // Pause for a status snapshot
        i_o_ready = 1'b0;
        check_loop();
      end else begin
        i_o_valid = o_armed && ($urandom_range(0, 3) != 0);
        i_o_ready = ($urandom_range(0, 3) != 0);
        if (i_o_valid && i_o_ready) begin
          model_step();
          beats++;
        end
      end
    end
    @(negedge clk);
    i_o_valid = 1'b0;
    i_o_ready = 1'b0;
    check_eq("o_done", o_done, 1);
    check_eq("o_armed", o_armed, 0);
    check_loop();
  endtask

  initial begin
    void'($urandom(SEED));
    repeat (5) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_eq("o_awready", o_awready, 0);
    check_eq("o_wready", o_wready, 0);
    check_eq("o_arready", o_arready, 0);
    check_eq("o_bvalid", o_bvalid, 0);
    check_eq("o_rvalid", o_rvalid, 0);
    check_eq("o_done", o_done, 0);
    check_eq("o_armed", o_armed, 0);

    axil_read(vec_pkg::REG_STATUS, rd);
    check_eq("o_rdata (status)", rd, 0);
    for (int k = 0; k < 4; k++) begin
      logic [31:0] v;
      v = $urandom_range(0, 16'hffff);
      axil_write(vec_pkg::REG_NB1, v);
      axil_read(vec_pkg::REG_NB1, rd);
      check_eq("o_rdata (nb1)", rd, v);
    end

    // Second pass restarts over a fresh table
    repeat (2) begin
      load_table();
      axil_read(7, rd);
      check_eq("o_rdata (unmapped)", rd, 0);
      axil_read(vec_pkg::N_REG + 5, rd); // Holds a nonzero coe by now
      check_eq("o_rdata (ram word)", rd, 0);
      start_run();
      run_beats();
      axil_read(vec_pkg::REG_STATUS, rd);
      check_eq("o_rdata (status)", rd, 1);
    end

    if (errors == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "errors seen");
    end
  end

endmodule

// File: bundle_ram/bundle_ram.sv
`timescale 1ns/1ps

module bundle_ram (
  input  logic                          clk,
  input  logic                          i_we,
  input  logic [vec_pkg::RAM_WR_AW-1:0] i_waddr,
  input  logic [vec_pkg::DATA_W-1:0]    i_wdata,
  input  logic                          i_re,
  input  logic [vec_pkg::RAM_RD_AW-1:0] i_raddr,
  output vec_pkg::bundle_t              o_rdata
);

  logic [vec_pkg::BUNDLE_WORDS-1:0][vec_pkg::DATA_W-1:0] mem [vec_pkg::MAX_BUNDLES];

  logic [vec_pkg::RAM_RD_AW-1:0] wr_row;
  logic [vec_pkg::SLICE_AW-1:0]  wr_slice;

  // Word k goes to row k/4, slice k%4
  assign wr_row   = i_waddr[vec_pkg::RAM_WR_AW-1:vec_pkg::SLICE_AW];
  assign wr_slice = i_waddr[vec_pkg::SLICE_AW-1:0];

  always_ff @(posedge clk) begin
    if (i_we)
      mem[wr_row][wr_slice] <= i_wdata;
  end

  always_ff @(posedge clk) begin
    if (i_re)
      o_rdata <= vec_pkg::bundle_t'(mem[i_raddr]); // Whole bundle per read
  end

endmodule

// File: common/vec_pkg.sv
package vec_pkg;

  localparam int DATA_W      = 32;
  localparam int ADDR_W      = 12;
  localparam int WORD_AW     = ADDR_W - 2; // AXI byte address to word address
  localparam int CW          = 16;
  localparam int MAX_BUNDLES = 16;
  localparam int N_REG       = 32;

  // Register word addresses
  localparam int REG_START  = 0;
  localparam int REG_NB1    = 1;
  localparam int REG_STATUS = 2;
  localparam int REG_LOOP   = 3;

  // p sits in the top half-word, kw just above the spare bits
  typedef struct packed {
    logic [CW-1:0] p;
    logic [CW-1:0] t;
    logic [CW-1:0] n;
    logic [CW-1:0] l;
    logic [CW-1:0] w_kw2;
    logic [CW-1:0] coe;
    logic [CW-1:0] kw;
    logic [CW-1:0] spare;
  } bundle_t;

  // Two counts per status word, i_b lowest
  typedef struct packed {
    logic [CW-1:0] i_wlast;
    logic [CW-1:0] i_coe;
    logic [CW-1:0] i_w_kw2;
    logic [CW-1:0] i_l;
    logic [CW-1:0] i_n;
    logic [CW-1:0] i_t;
    logic [CW-1:0] i_p;
    logic [CW-1:0] i_b;
  } loop_state_t;

  localparam int BUNDLE_WORDS = $bits(bundle_t) / DATA_W;
  localparam int LOOP_WORDS   = $bits(loop_state_t) / DATA_W;
  localparam int SLICE_AW     = $clog2(BUNDLE_WORDS);
  localparam int RAM_RD_AW    = $clog2(MAX_BUNDLES);
  localparam int RAM_WR_AW    = RAM_RD_AW + SLICE_AW;

endpackage

// File: design/axil_cfg_port.sv
`timescale 1ns/1ps

module axil_cfg_port (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic [vec_pkg::ADDR_W-1:0]     i_awaddr,
  input  logic                           i_awvalid,
  output logic                           o_awready,
  input  logic [vec_pkg::DATA_W-1:0]     i_wdata,
  input  logic                           i_wvalid,
  output logic                           o_wready,
  output logic                           o_bvalid,
  input  logic                           i_bready,
  input  logic [vec_pkg::ADDR_W-1:0]     i_araddr,
  input  logic                           i_arvalid,
  output logic                           o_arready,
  output logic [vec_pkg::DATA_W-1:0]     o_rdata,
  output logic                           o_rvalid,
  input  logic                           i_rready,
  output logic                           o_ram_we,
  output logic [vec_pkg::RAM_WR_AW-1:0]  o_ram_waddr,
  output logic [vec_pkg::DATA_W-1:0]     o_ram_wdata,
  output logic                           o_start,
  output logic [vec_pkg::CW-1:0]         o_nb1,
  input  vec_pkg::loop_state_t           i_loop,
  input  logic                           i_done,
  input  logic                           i_armed
);

  logic                                              wr_acc, rd_acc;
  logic [vec_pkg::WORD_AW-1:0]                       wr_word, rd_word;
  logic [vec_pkg::DATA_W-1:0]                        rd_mux;
  logic [vec_pkg::LOOP_WORDS-1:0][vec_pkg::DATA_W-1:0] loop_words;

  assign wr_word    = i_awaddr[vec_pkg::ADDR_W-1:2];
  assign rd_word    = i_araddr[vec_pkg::ADDR_W-1:2];
  assign wr_acc     = o_awready && i_awvalid && i_wvalid;
  assign rd_acc     = o_arready && i_arvalid;
  assign loop_words = i_loop;

  assign o_wready = o_awready; // AW and W always taken together

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_awready <= 1'b0;
      o_bvalid  <= 1'b0;
    end else begin
      o_awready <= i_awvalid && i_wvalid && !o_awready && !o_bvalid;
      if (wr_acc)
        o_bvalid <= 1'b1;
      else if (i_bready)
        o_bvalid <= 1'b0;
    end
  end

  // Bundle words live above the register window
  assign o_ram_we    = wr_acc && (wr_word >= vec_pkg::N_REG);
  assign o_ram_waddr = vec_pkg::RAM_WR_AW'(wr_word - vec_pkg::N_REG);
  assign o_ram_wdata = i_wdata;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_start <= 1'b0;
      o_nb1   <= '0;
    end else begin
      o_start <= wr_acc && (wr_word == vec_pkg::REG_START);
      if (wr_acc && (wr_word == vec_pkg::REG_NB1))
        o_nb1 <= i_wdata[vec_pkg::CW-1:0];
    end
  end

  always_comb begin
    rd_mux = '0;
    if (rd_word == vec_pkg::REG_NB1) begin
      rd_mux = vec_pkg::DATA_W'(o_nb1);
    end else if (rd_word == vec_pkg::REG_STATUS) begin
      rd_mux = {{(vec_pkg::DATA_W-2){1'b0}}, i_armed, i_done};
    end else if ((rd_word >= vec_pkg::REG_LOOP) &&
                 (rd_word < vec_pkg::REG_LOOP + vec_pkg::LOOP_WORDS)) begin
      rd_mux = loop_words[rd_word - vec_pkg::REG_LOOP];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      o_arready <= i_arvalid && !o_arready && !o_rvalid;
      if (rd_acc)
        o_rvalid <= 1'b1;
      else if (i_rready)
        o_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc)
      o_rdata <= rd_mux;
  end

endmodule

// File: design/vector_cfg_top.sv
`timescale 1ns/1ps

module vector_cfg_top (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic [vec_pkg::ADDR_W-1:0] i_awaddr,
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  logic [vec_pkg::DATA_W-1:0] i_wdata,
  input  logic                       i_wvalid,
  output logic                       o_wready,
  output logic                       o_bvalid,
  input  logic                       i_bready,
  input  logic [vec_pkg::ADDR_W-1:0] i_araddr,
  input  logic                       i_arvalid,
  output logic                       o_arready,
  output logic [vec_pkg::DATA_W-1:0] o_rdata,
  output logic                       o_rvalid,
  input  logic                       i_rready,
  input  logic                       i_o_valid,
  input  logic                       i_o_ready,
  output logic                       o_done,
  output logic                       o_armed
);

  logic                          ram_we, ram_re, start;
  logic [vec_pkg::RAM_WR_AW-1:0] ram_waddr;
  logic [vec_pkg::RAM_RD_AW-1:0] ram_raddr;
  logic [vec_pkg::DATA_W-1:0]    ram_wdata;
  logic [vec_pkg::CW-1:0]        nb1;
  vec_pkg::bundle_t              ram_rdata;
  vec_pkg::loop_state_t          loop_state;

  axil_cfg_port port_i (
    .clk(clk), .rstn(rstn),
    .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
    .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
    .o_bvalid(o_bvalid), .i_bready(i_bready),
    .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
    .o_rdata(o_rdata), .o_rvalid(o_rvalid), .i_rready(i_rready),
    .o_ram_we(ram_we), .o_ram_waddr(ram_waddr), .o_ram_wdata(ram_wdata),
    .o_start(start), .o_nb1(nb1),
    .i_loop(loop_state), .i_done(o_done), .i_armed(o_armed)
  );

  bundle_ram ram_i (
    .clk(clk),
    .i_we(ram_we), .i_waddr(ram_waddr), .i_wdata(ram_wdata),
    .i_re(ram_re), .i_raddr(ram_raddr), .o_rdata(ram_rdata)
  );

  beat_tracker tracker_i (
    .clk(clk), .rstn(rstn),
    .i_start(start), .i_nb1(nb1),
    .o_ram_re(ram_re), .o_ram_raddr(ram_raddr), .i_ram_data(ram_rdata),
    .i_o_valid(i_o_valid), .i_o_ready(i_o_ready),
    .o_loop(loop_state), .o_done(o_done), .o_armed(o_armed)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_vector_cfg -f src.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run ok" || { echo "run failed"; exit 1; }

// File: src.f
common/vec_pkg.sv
bundle_ram/bundle_ram.sv
beat_tracker/loop_counter.sv
beat_tracker/beat_tracker.sv
design/axil_cfg_port.sv
design/vector_cfg_top.sv
bench/tb_vector_cfg.sv
